//--- logic/dwnld_defs.svh
// build-time layout, needs BA1 < BA2 < BA3 < PROM_START, PROM_AW <= BANK_AW, ACK_LAT >= 2
`ifndef DWNLD_DEFS_SVH
`define DWNLD_DEFS_SVH

//////////////////////////////////////////////////
// loader stream layout

// the header is the first bytes of the stream and never reaches memory
`define DW_HEADER_LEN 4

// payload byte offsets, counted after the header, where banks 1 to 3 start
`define DW_BA1_START  'h080
`define DW_BA2_START  'h100
`define DW_BA3_START  'h180

// payload bytes from here on go to the on-chip PROM
`define DW_PROM_START 'h200

// width of the loader byte address
`define DW_IOCTL_AW   25

//////////////////////////////////////////////////
// memory sizes and timing

// PROM holds 2**DW_PROM_AW bytes and each bank 2**DW_BANK_AW words
`define DW_PROM_AW    6
`define DW_BANK_AW    6

// cycles from the first cycle a write is seen to its acknowledge
`define DW_ACK_LAT    3

// set to 1 to swap the two bytes of every payload word
`define DW_SWAB       0

`endif

//--- logic/dwnld_pkg.sv
// shared types of the download path, the enums are two bits wide and fixed per build
package dwnld_pkg;

    // where the byte on the loader bus is heading this cycle
    // TGT_NONE also covers cycles with no accepted strobe
    typedef enum logic [1:0] {
        TGT_HEADER = 2'd0,
        TGT_SDRAM  = 2'd1,
        TGT_PROM   = 2'd2,
        TGT_NONE   = 2'd3
    } dw_target_e;

    // write port of the behavioural SDRAM
    // SP_WAIT burns the ack latency and SP_ACK is the single ack cycle
    typedef enum logic [1:0] {
        SP_IDLE = 2'd0,
        SP_WAIT = 2'd1,
        SP_ACK  = 2'd2
    } sdram_state_e;

    // one of the four SDRAM banks
    typedef logic [1:0] bank_t;

endpackage

//--- logic/prom_store.sv
// PROM byte store of 2**DW_PROM_AW entries, contents are undefined until loaded, no reset
`timescale 1ns/10ps
`include "dwnld_defs.svh"

module prom_store (
    input  logic                   clk,
    input  logic                   prom_we,
    input  logic [`DW_PROM_AW-1:0] prom_addr,
    input  logic [7:0]             prom_data,
    input  logic [`DW_PROM_AW-1:0] prom_rd_addr,
    output logic [7:0]             prom_rd_data
);

    localparam int DEPTH = 2 ** `DW_PROM_AW;

    logic [7:0] mem [0:DEPTH-1];

    //////////////////////////////////////////////////
    // write side

    // every prom_we pulse carries exactly one byte
    always_ff @(posedge clk) begin
        if (prom_we)
            mem[prom_addr] <= prom_data;
    end

    //////////////////////////////////////////////////
    // read side

    // asynchronous read so the contents can be checked at any time
    assign prom_rd_data = mem[prom_rd_addr];

endmodule

//--- logic/sdram_bank_port.sv
// behavioural SDRAM write port, no refresh or bursts, needs DW_ACK_LAT >= 2 and a request held until ack
`timescale 1ns/10ps
`include "dwnld_defs.svh"

module sdram_bank_port (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   prog_we,
    input  logic [`DW_BANK_AW-1:0] prog_addr,
    input  dwnld_pkg::bank_t       prog_ba,
    input  logic [15:0]            prog_data,
    input  logic [1:0]             prog_mask,
    output logic                   sdram_ack,
    input  dwnld_pkg::bank_t       rd_ba,
    input  logic [`DW_BANK_AW-1:0] rd_addr,
    output logic [15:0]            rd_data
);
    import dwnld_pkg::*;

    localparam int DEPTH = 4 * (2 ** `DW_BANK_AW);
    localparam int CNT_W = $clog2(`DW_ACK_LAT) + 1;

    sdram_state_e   state;
    logic [CNT_W-1:0] wait_cnt;
    logic [15:0]    mem [0:DEPTH-1];

    //////////////////////////////////////////////////
    // ack timing

    // IDLE sees the request, WAIT covers the next DW_ACK_LAT-1 cycles
    // and ACK is the cycle the ack is shown and the word is written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= SP_IDLE;
            wait_cnt <= '0;
        end else begin
            case (state)
                SP_IDLE: begin
                    if (prog_we) begin
                        state    <= SP_WAIT;
                        wait_cnt <= '0;
                    end
                end
                SP_WAIT: begin
                    // a withdrawn request means the download was aborted
                    if (!prog_we)
                        state <= SP_IDLE;
                    else if (wait_cnt == CNT_W'(`DW_ACK_LAT - 2))
                        state <= SP_ACK;
                    else
                        wait_cnt <= wait_cnt + 1'b1;
                end
                SP_ACK: begin
                    state <= SP_IDLE;
                end
                default: begin
                    state <= SP_IDLE;
                end
            endcase
        end
    end

    assign sdram_ack = (state == SP_ACK);

    //////////////////////////////////////////////////
    // bank storage

    // the four banks sit back to back, the bank index is the top address bits
    always_ff @(posedge clk) begin
        if (state == SP_ACK && prog_we) begin
            if (!prog_mask[0])
                mem[{prog_ba, prog_addr}][7:0] <= prog_data[7:0];
            if (!prog_mask[1])
                mem[{prog_ba, prog_addr}][15:8] <= prog_data[15:8];
        end
    end

    // read back is combinational, used to inspect the loaded image
    assign rd_data = mem[{rd_ba, rd_addr}];

    //////////////////////////////////////////////////
    // checks

    // the decode side must not change a request while it is being served
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (state == SP_WAIT && prog_we) |-> $stable({prog_addr, prog_ba, prog_data, prog_mask}));

endmodule

//--- logic/dwnld_decode.sv
// assumes the loader honours ready, one SDRAM write in flight, PROM address in prog_addr low bits
`timescale 1ns/10ps
`include "dwnld_defs.svh"

module dwnld_decode (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        downloading,
    input  logic [`DW_IOCTL_AW-1:0]     ioctl_addr,
    input  logic [7:0]                  ioctl_data,
    input  logic                        ioctl_wr,
    input  logic                        sdram_ack,
    output logic                        ready,
    output logic                        prog_we,
    output logic [`DW_BANK_AW-1:0]      prog_addr,
    output dwnld_pkg::bank_t            prog_ba,
    output logic [15:0]                 prog_data,
    output logic [1:0]                  prog_mask,
    output logic                        prom_we,
    output logic [8*`DW_HEADER_LEN-1:0] hdr_cfg
);
    import dwnld_pkg::*;

    dw_target_e              target;
    bank_t                   bank;
    logic [`DW_IOCTL_AW-1:0] part_addr;
    logic [`DW_IOCTL_AW-1:0] bank_start;
    logic [`DW_IOCTL_AW-1:0] eff_addr;
    logic [`DW_IOCTL_AW-1:0] prom_off;
    logic                    lane;
    logic [7:0]              data_out;

    //////////////////////////////////////////////////
    // address decode

    // payload address with the header stripped off
    assign part_addr = ioctl_addr - `DW_IOCTL_AW'(`DW_HEADER_LEN);
    assign prom_off  = part_addr - `DW_IOCTL_AW'(`DW_PROM_START);

    // a strobe only counts while a download is running
    always_comb begin
        if (!(ioctl_wr && downloading))
            target = TGT_NONE;
        else if (ioctl_addr < `DW_IOCTL_AW'(`DW_HEADER_LEN))
            target = TGT_HEADER;
        else if (part_addr >= `DW_IOCTL_AW'(`DW_PROM_START))
            target = TGT_PROM;
        else
            target = TGT_SDRAM;
    end

    // the highest bank start not above the payload address wins
    always_comb begin
        if (part_addr >= `DW_IOCTL_AW'(`DW_BA3_START))
            bank = 2'd3;
        else if (part_addr >= `DW_IOCTL_AW'(`DW_BA2_START))
            bank = 2'd2;
        else if (part_addr >= `DW_IOCTL_AW'(`DW_BA1_START))
            bank = 2'd1;
        else
            bank = 2'd0;
        case (bank)
            2'd1:    bank_start = `DW_IOCTL_AW'(`DW_BA1_START);
            2'd2:    bank_start = `DW_IOCTL_AW'(`DW_BA2_START);
            2'd3:    bank_start = `DW_IOCTL_AW'(`DW_BA3_START);
            default: bank_start = '0;
        endcase
    end

    // byte offset inside its bank, bit 0 picks the lane
    assign eff_addr = part_addr - bank_start;
    assign lane     = eff_addr[0] ^ 1'(`DW_SWAB);

    //////////////////////////////////////////////////
    // request registers

    // prog_we is held until the SDRAM side acks, an aborted download drops it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
            hdr_cfg <= '0;
        end else begin
            prom_we <= (target == TGT_PROM);
            if (!downloading)
                prog_we <= 1'b0;
            else if (target == TGT_SDRAM)
                prog_we <= 1'b1;
            else if (sdram_ack)
                prog_we <= 1'b0;
            // header bytes fill hdr_cfg from the low byte up
            for (int i = 0; i < `DW_HEADER_LEN; i++) begin
                if (target == TGT_HEADER && ioctl_addr == `DW_IOCTL_AW'(i))
                    hdr_cfg[8*i +: 8] <= ioctl_data;
            end
        end
    end

    // payload of the request, only meaningful while a write strobe is up
    always_ff @(posedge clk) begin
        if (target == TGT_SDRAM) begin
            prog_addr <= eff_addr[`DW_BANK_AW:1];
            prog_ba   <= bank;
            prog_mask <= lane ? 2'b01 : 2'b10;
            data_out  <= ioctl_data;
        end else if (target == TGT_PROM) begin
            prog_addr <= prom_off[`DW_BANK_AW-1:0];
            data_out  <= ioctl_data;
        end
    end

    // the byte rides on both lanes and the mask picks one
    assign prog_data = {2{data_out}};
    assign ready     = !prog_we;

    //////////////////////////////////////////////////
    // checks

    // the loader must wait for ready before the next byte
    a_no_wr_busy: assert property (@(posedge clk) disable iff (!rst_n)
        ioctl_wr |-> ready);

    a_one_lane: assert property (@(posedge clk) disable iff (!rst_n)
        prog_we |-> $onehot(~prog_mask));

    // the ack from the SDRAM port retires the request on the next edge
    a_ack_drop: assert property (@(posedge clk) disable iff (!rst_n)
        (prog_we && sdram_ack) |=> !prog_we);

endmodule

//--- logic/rom_dwnld_top.sv
// ROM download top, loader must wait for ready between bytes, layout fixed by dwnld_defs.svh
`timescale 1ns/10ps
`include "dwnld_defs.svh"

module rom_dwnld_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        downloading,
    input  logic [`DW_IOCTL_AW-1:0]     ioctl_addr,
    input  logic [7:0]                  ioctl_data,
    input  logic                        ioctl_wr,
    output logic                        ready,
    output logic [8*`DW_HEADER_LEN-1:0] hdr_cfg,
    input  dwnld_pkg::bank_t            rd_ba,
    input  logic [`DW_BANK_AW-1:0]      rd_addr,
    output logic [15:0]                 rd_data,
    input  logic [`DW_PROM_AW-1:0]      prom_rd_addr,
    output logic [7:0]                  prom_rd_data
);
    import dwnld_pkg::*;

    // decode to SDRAM and PROM
    logic                   prog_we;
    logic [`DW_BANK_AW-1:0] prog_addr;
    bank_t                  prog_ba;
    logic [15:0]            prog_data;
    logic [1:0]             prog_mask;
    logic                   prom_we;
    logic                   sdram_ack;

    dwnld_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .sdram_ack   (sdram_ack),
        .ready       (ready),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_ba     (prog_ba),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prom_we     (prom_we),
        .hdr_cfg     (hdr_cfg)
    );

    sdram_bank_port u_sdram (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_ba   (prog_ba),
        .prog_data (prog_data),
        .prog_mask (prog_mask),
        .sdram_ack (sdram_ack),
        .rd_ba     (rd_ba),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    // the PROM takes the low address bits and one copy of the byte
    prom_store u_prom (
        .clk          (clk),
        .prom_we      (prom_we),
        .prom_addr    (prog_addr[`DW_PROM_AW-1:0]),
        .prom_data    (prog_data[7:0]),
        .prom_rd_addr (prom_rd_addr),
        .prom_rd_data (prom_rd_data)
    );

endmodule

//--- verification/rom_dwnld_tb.sv
// drives one random ROM image through the loader port, expects DW_PROM_AW=6 and a header of at most 4 bytes
`timescale 1ns/10ps
`include "dwnld_defs.svh"

module rom_dwnld_tb;

    localparam int CLK_NS      = 100;
    localparam int BANK_WORDS  = 2 ** `DW_BANK_AW;
    localparam int PROM_BYTES  = 2 ** `DW_PROM_AW;
    localparam int N_BYTES     = `DW_HEADER_LEN + `DW_PROM_START + PROM_BYTES;
    // every byte may cost the ack latency plus handshake cycles, readback and margin come on top
    localparam int READ_CYCLES = 4 * BANK_WORDS + PROM_BYTES + 200;
    localparam int WATCHDOG_NS = (N_BYTES * (`DW_ACK_LAT + 6) + READ_CYCLES) * CLK_NS;

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        downloading;
    logic [`DW_IOCTL_AW-1:0]     ioctl_addr;
    logic [7:0]                  ioctl_data;
    logic                        ioctl_wr;
    logic                        ready;
    logic [8*`DW_HEADER_LEN-1:0] hdr_cfg;
    logic [1:0]                  rd_ba;
    logic [`DW_BANK_AW-1:0]      rd_addr;
    logic [15:0]                 rd_data;
    logic [`DW_PROM_AW-1:0]      prom_rd_addr;
    logic [7:0]                  prom_rd_data;

    // the whole ROM image as the loader sends it, header first
    logic [7:0] image [0:N_BYTES-1];
    int         err_count;
    int         check_count;
    int         tests_run;
    int         tests_failed;

    rom_dwnld_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .downloading  (downloading),
        .ioctl_addr   (ioctl_addr),
        .ioctl_data   (ioctl_data),
        .ioctl_wr     (ioctl_wr),
        .ready        (ready),
        .hdr_cfg      (hdr_cfg),
        .rd_ba        (rd_ba),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .prom_rd_addr (prom_rd_addr),
        .prom_rd_data (prom_rd_data)
    );

    always #(CLK_NS / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // reference model and helpers

    // kind 0 gives the header, kind 1 the bank word at idx = bank * BANK_WORDS + word,
    // kind 2 the PROM byte at idx
    function automatic logic [31:0] expected_value(input int kind, input int idx);
        int          bank;
        int          word;
        int          start;
        int          part;
        logic [31:0] result;
        result = '0;
        case (kind)
            0: begin
                for (int i = 0; i < `DW_HEADER_LEN; i++)
                    result[8*i +: 8] = image[i];
            end
            1: begin
                bank = idx / BANK_WORDS;
                word = idx % BANK_WORDS;
                case (bank)
                    1:       start = `DW_BA1_START;
                    2:       start = `DW_BA2_START;
                    3:       start = `DW_BA3_START;
                    default: start = 0;
                endcase
                // lane 0 is the low byte and takes the even offset unless swapped
                for (int lane = 0; lane < 2; lane++) begin
                    part = start + 2 * word + (lane ^ `DW_SWAB);
                    result[8*lane +: 8] = image[`DW_HEADER_LEN + part];
                end
            end
            default: result[7:0] = image[`DW_HEADER_LEN + `DW_PROM_START + idx];
        endcase
        return result;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("MISMATCH time=%0t signal=%s got=0x%0h expected=0x%0h",
                     $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_count != errs_before) begin
            tests_failed++;
            $display("test %0d %s: FAIL, %0d mismatches", tests_run, name,
                     err_count - errs_before);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
    endtask

    // ready is sampled mid cycle, the strobe is then raised for one clock
    task automatic send_byte(input int addr, input logic [7:0] data);
        @(negedge clk);
        while (!ready)
            @(negedge clk);
        @(posedge clk);
        ioctl_addr <= `DW_IOCTL_AW'(addr);
        ioctl_data <= data;
        ioctl_wr   <= 1'b1;
        @(posedge clk);
        ioctl_wr   <= 1'b0;
    endtask

    task automatic read_bank_word(input int bank, input int word, output logic [15:0] value);
        @(posedge clk);
        rd_ba   <= 2'(bank);
        rd_addr <= `DW_BANK_AW'(word);
        @(negedge clk);
        value = rd_data;
    endtask

    //////////////////////////////////////////////////
    // test sequence

    initial begin
        int          seed_val;
        int          errs_before;
        logic [15:0] word_val;
        rst_n        = 1'b0;
        downloading  = 1'b0;
        ioctl_addr   = '0;
        ioctl_data   = '0;
        ioctl_wr     = 1'b0;
        rd_ba        = '0;
        rd_addr      = '0;
        prom_rd_addr = '0;
        err_count    = 0;
        check_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        seed_val     = $urandom(32'h49d8);
        for (int i = 0; i < N_BYTES; i++)
            image[i] = 8'($urandom());
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        errs_before = err_count;
        @(negedge clk);
        check_value("ready", 32'(ready), 32'd1);
        check_value("hdr_cfg", 32'(hdr_cfg), 32'd0);
        report_test("reset state", errs_before);

        // full image, one byte per handshake
        @(posedge clk);
        downloading <= 1'b1;
        for (int i = 0; i < N_BYTES; i++)
            send_byte(i, image[i]);
        // the last write must retire before the download closes
        @(negedge clk);
        while (!ready)
            @(negedge clk);
        @(posedge clk);
        downloading <= 1'b0;

        errs_before = err_count;
        @(negedge clk);
        check_value("hdr_cfg", 32'(hdr_cfg), expected_value(0, 0));
        report_test("header capture", errs_before);

        errs_before = err_count;
        for (int b = 0; b < 4; b++) begin
            for (int w = 0; w < BANK_WORDS; w++) begin
                read_bank_word(b, w, word_val);
                check_value($sformatf("rd_data[bank %0d word %0d]", b, w), 32'(word_val),
                            expected_value(1, b * BANK_WORDS + w));
            end
        end
        report_test("bank contents", errs_before);

        errs_before = err_count;
        for (int a = 0; a < PROM_BYTES; a++) begin
            @(posedge clk);
            prom_rd_addr <= `DW_PROM_AW'(a);
            @(negedge clk);
            check_value($sformatf("prom_rd_data[%0d]", a), 32'(prom_rd_data),
                        expected_value(2, a));
        end
        report_test("PROM contents", errs_before);

        // strobes outside a download aim at bank 0 word 0 with inverted data
        errs_before = err_count;
        for (int n = 0; n < 4; n++) begin
            @(posedge clk);
            ioctl_addr <= `DW_IOCTL_AW'(`DW_HEADER_LEN);
            ioctl_data <= ~image[`DW_HEADER_LEN];
            ioctl_wr   <= 1'b1;
            @(posedge clk);
            ioctl_wr   <= 1'b0;
            repeat (`DW_ACK_LAT + 2) begin
                @(negedge clk);
                check_value("ready", 32'(ready), 32'd1);
            end
        end
        read_bank_word(0, 0, word_val);
        check_value("rd_data[bank 0 word 0]", 32'(word_val), expected_value(1, 0));
        report_test("strobes while idle", errs_before);

        $display("tests run %0d, passed %0d, failed %0d, checks %0d, mismatches %0d",
                 tests_run, tests_run - tests_failed, tests_failed, check_count, err_count);
        if (tests_failed == 0 && err_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // a stuck handshake would leave the stream loop waiting forever
    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: the download hung, the run did not end within %0d ns", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- rom_dwnld_top.f
+incdir+logic
logic/dwnld_pkg.sv
logic/prom_store.sv
logic/sdram_bank_port.sv
logic/dwnld_decode.sv
logic/rom_dwnld_top.sv
verification/rom_dwnld_tb.sv
